/* Bender.yml */
package:
  name: uart_mon

sources:
  - files:
      - common/uart_mon_pkg.sv
      - hdl/uart_rx.sv
      - hdl/uart_tx.sv
      - scan/scan.sv
      - monitor/mon_ctrl.sv
      - hdl/uart_mon_top.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_uart_mon.sv

/* common/uart_mon_pkg.sv */
package uart_mon_pkg;

    //////////////////////////////////////////////////////////////////////
    // serial timing and store geometry
    //////////////////////////////////////////////////////////////////////

    // clock cycles per serial bit, kept small for short simulations
    localparam int clks_per_bit = 8;

    localparam int mem_aw      = 8;  // 256-byte store
    localparam int addr_digits = 4;  // hex digits per address token

    //////////////////////////////////////////////////////////////////////
    // character codes
    //////////////////////////////////////////////////////////////////////

    localparam logic [7:0] chr_cr = 8'h0d;
    localparam logic [7:0] chr_lf = 8'h0a;
    localparam logic [7:0] chr_sp = 8'h20;

    // command and reply characters
    localparam logic [7:0] chr_w = 8'h77;  // "w"
    localparam logic [7:0] chr_r = 8'h72;  // "r"
    localparam logic [7:0] chr_k = 8'h6b;  // "k"
    localparam logic [7:0] chr_q = 8'h3f;  // "?"

    //////////////////////////////////////////////////////////////////////
    // scanner request and result
    //////////////////////////////////////////////////////////////////////

    // token kind asked for together with scan_req
    typedef enum logic {
        scan_byte = 1'b0,
        scan_addr = 1'b1
    } scan_kind_e;

    // result of one token request
    // raw characters land zero-extended in the low byte of value
    typedef struct packed {
        logic        abort;  // request ended by CR LF
        logic [15:0] value;
    } scan_res_t;

endpackage

/* hdl/uart_mon_top.sv */
module uart_mon_top (
    input  logic clk,
    input  logic rst,
    input  logic rxd,
    output logic txd
);

    logic [7:0]               rx_data;
    logic                     rx_vld;
    logic                     scan_req;
    uart_mon_pkg::scan_kind_e scan_kind;
    logic                     scan_done;
    uart_mon_pkg::scan_res_t  scan_res;
    logic [7:0]               tx_data;
    logic                     tx_start;
    logic                     tx_busy;

    uart_rx i_uart_rx (
        .clk     (clk),
        .rst     (rst),
        .rxd     (rxd),
        .rx_data (rx_data),
        .rx_vld  (rx_vld)
    );

    // token scanner between receiver and sequencer
    scan i_scan (
        .clk       (clk),
        .rst       (rst),
        .rx_data   (rx_data),
        .rx_vld    (rx_vld),
        .scan_req  (scan_req),
        .scan_kind (scan_kind),
        .scan_done (scan_done),
        .scan_res  (scan_res)
    );

    mon_ctrl i_mon_ctrl (
        .clk       (clk),
        .rst       (rst),
        .scan_done (scan_done),
        .scan_res  (scan_res),
        .tx_busy   (tx_busy),
        .scan_req  (scan_req),
        .scan_kind (scan_kind),
        .tx_data   (tx_data),
        .tx_start  (tx_start)
    );

    uart_tx i_uart_tx (
        .clk      (clk),
        .rst      (rst),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .txd      (txd),
        .tx_busy  (tx_busy)
    );

endmodule

/* hdl/uart_rx.sv */
module uart_rx (
    input  logic       clk,
    input  logic       rst,
    input  logic       rxd,
    output logic [7:0] rx_data,
    output logic       rx_vld
);

    typedef enum logic [1:0] {
        rs_idle,
        rs_start,
        rs_data,
        rs_stop
    } rx_state_e;

    rx_state_e state;
    logic      rxd_meta;
    logic      rxd_sync;
    logic      rxd_prev;  // for start edge detection
    logic [$clog2(uart_mon_pkg::clks_per_bit)-1:0] cnt;
    logic [2:0] bit_idx;

    // two-flop synchronizer, line idles high
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end
        else
        begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state   <= rs_idle;
            cnt     <= '0;
            bit_idx <= '0;
            rx_vld  <= 1'b0;
        end
        else
        begin
            rx_vld <= 1'b0;
            case (state)
                rs_idle:
                begin
                    cnt <= '0;
                    if (rxd_prev && !rxd_sync)  // falling edge
                        state <= rs_start;
                end
                rs_start:
                begin
                    if (cnt == uart_mon_pkg::clks_per_bit / 2 - 1)
                    begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        // glitch check at mid start bit
                        state   <= rxd_sync ? rs_idle : rs_data;
                    end
                    else
                        cnt <= cnt + 1'b1;
                end
                rs_data:
                begin
                    if (cnt == uart_mon_pkg::clks_per_bit - 1)
                    begin
                        cnt <= '0;
                        if (bit_idx == 3'd7)
                            state <= rs_stop;
                        else
                            bit_idx <= bit_idx + 1'b1;
                    end
                    else
                        cnt <= cnt + 1'b1;
                end
                rs_stop:
                begin
                    if (cnt == uart_mon_pkg::clks_per_bit - 1)
                    begin
                        rx_vld <= 1'b1;  // no framing check
                        state  <= rs_idle;
                    end
                    else
                        cnt <= cnt + 1'b1;
                end
                default: state <= rs_idle;
            endcase
        end
    end

    // lsb first, bits enter from the top
    always_ff @(posedge clk)
    begin
        if (state == rs_data && cnt == uart_mon_pkg::clks_per_bit - 1)
            rx_data <= {rxd_sync, rx_data[7:1]};
    end

endmodule

/* hdl/uart_tx.sv */
module uart_tx (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] tx_data,
    input  logic       tx_start,
    output logic       txd,
    output logic       tx_busy
);

    logic [8:0] shreg;  // data bits then stop bit
    logic [3:0] bit_idx;  // 0 start, 1..8 data, 9 stop
    logic [$clog2(uart_mon_pkg::clks_per_bit)-1:0] cnt;

    //////////////////////////////////////////////////////////////////////
    // frame sequencing
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            txd     <= 1'b1;
            tx_busy <= 1'b0;
            bit_idx <= '0;
            cnt     <= '0;
        end
        else if (!tx_busy)
        begin
            if (tx_start)
            begin
                txd     <= 1'b0;  // start bit
                tx_busy <= 1'b1;
                bit_idx <= '0;
                cnt     <= '0;
            end
        end
        else if (cnt == uart_mon_pkg::clks_per_bit - 1)
        begin
            cnt <= '0;
            if (bit_idx == 4'd9)
                tx_busy <= 1'b0;  // end of stop bit, txd already high
            else
            begin
                txd     <= shreg[0];
                bit_idx <= bit_idx + 1'b1;
            end
        end
        else
            cnt <= cnt + 1'b1;
    end

    // shift register holds payload only
    always_ff @(posedge clk)
    begin
        if (!tx_busy && tx_start)
            shreg <= {1'b1, tx_data};
        else if (tx_busy && cnt == uart_mon_pkg::clks_per_bit - 1)
            shreg <= {1'b1, shreg[8:1]};
    end

endmodule

/* monitor/mon_ctrl.sv */
module mon_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     scan_done,
    input  uart_mon_pkg::scan_res_t  scan_res,
    input  logic                     tx_busy,
    output logic                     scan_req,
    output uart_mon_pkg::scan_kind_e scan_kind,
    output logic [7:0]               tx_data,
    output logic                     tx_start
);

    typedef enum logic [2:0] {
        mc_boot,
        mc_cmd,
        mc_waddr,
        mc_wdata,
        mc_raddr,
        mc_reply
    } state_e;

    state_e     state;
    logic [1:0] rstep;  // 0 reply char, 1 CR, 2 LF, 3 drain
    logic [7:0] reply_chr;
    logic [7:0] mem [2**uart_mon_pkg::mem_aw];
    logic [uart_mon_pkg::mem_aw-1:0] waddr;
    logic       tok_ok;
    logic       tx_free;
    logic       is_w;
    logic       is_r;

    assign tok_ok  = scan_done && !scan_res.abort;
    assign tx_free = !tx_busy && !tx_start;  // busy lags start by a cycle
    assign is_w    = (scan_res.value[7:0] == uart_mon_pkg::chr_w);
    assign is_r    = (scan_res.value[7:0] == uart_mon_pkg::chr_r);

    //////////////////////////////////////////////////////////////////////
    // command sequencer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state     <= mc_boot;
            scan_req  <= 1'b0;
            scan_kind <= uart_mon_pkg::scan_byte;
            tx_start  <= 1'b0;
            rstep     <= '0;
        end
        else
        begin
            scan_req <= 1'b0;
            tx_start <= 1'b0;
            if (scan_done && scan_res.abort)
            begin
                // silent restart
                scan_kind <= uart_mon_pkg::scan_byte;
                scan_req  <= 1'b1;
                state     <= mc_cmd;
            end
            else
            begin
                case (state)
                    mc_boot:
                    begin
                        scan_req <= 1'b1;
                        state    <= mc_cmd;
                    end
                    mc_cmd:
                    begin
                        if (scan_done)
                        begin
                            rstep <= '0;
                            if (is_w || is_r)
                            begin
                                scan_kind <= uart_mon_pkg::scan_addr;
                                scan_req  <= 1'b1;
                                state     <= is_w ? mc_waddr : mc_raddr;
                            end
                            else
                                state <= mc_reply;  // unknown command
                        end
                    end
                    mc_waddr:
                    begin
                        if (scan_done)
                        begin
                            scan_kind <= uart_mon_pkg::scan_byte;
                            scan_req  <= 1'b1;
                            state     <= mc_wdata;
                        end
                    end
                    mc_wdata,
                    mc_raddr:
                    begin
                        if (scan_done)
                            state <= mc_reply;
                    end
                    mc_reply:
                    begin
                        if (tx_free)
                        begin
                            if (rstep == 2'd3)
                            begin
                                // LF fully sent, listen again
                                scan_kind <= uart_mon_pkg::scan_byte;
                                scan_req  <= 1'b1;
                                state     <= mc_cmd;
                            end
                            else
                            begin
                                tx_start <= 1'b1;
                                rstep    <= rstep + 1'b1;
                            end
                        end
                    end
                    default: state <= mc_boot;
                endcase
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // store and reply data
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (state == mc_waddr && tok_ok)
            waddr <= scan_res.value[uart_mon_pkg::mem_aw-1:0];
        if (state == mc_wdata && tok_ok)
        begin
            mem[waddr] <= scan_res.value[7:0];
            reply_chr  <= uart_mon_pkg::chr_k;
        end
        if (state == mc_raddr && tok_ok)
            reply_chr <= mem[scan_res.value[uart_mon_pkg::mem_aw-1:0]];
        if (state == mc_cmd && tok_ok && !is_w && !is_r)
            reply_chr <= uart_mon_pkg::chr_q;
        if (state == mc_reply && tx_free)
        begin
            case (rstep)
                2'd0:    tx_data <= reply_chr;
                2'd1:    tx_data <= uart_mon_pkg::chr_cr;
                default: tx_data <= uart_mon_pkg::chr_lf;
            endcase
        end
    end

endmodule

/* scan/scan.sv */
module scan (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [7:0]               rx_data,
    input  logic                     rx_vld,
    input  logic                     scan_req,
    input  uart_mon_pkg::scan_kind_e scan_kind,
    output logic                     scan_done,
    output uart_mon_pkg::scan_res_t  scan_res
);

    typedef enum logic [2:0] {
        st_idle,
        st_byte,
        st_addr,
        st_enter,   // CR seen, waiting for LF
        st_done
    } state_e;

    state_e     state;
    logic       is_hex;
    logic [3:0] nib;
    logic [$clog2(uart_mon_pkg::addr_digits)-1:0] dig_cnt;

    //////////////////////////////////////////////////////////////////////
    // hex digit decode
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        is_hex = 1'b1;
        nib    = 4'h0;
        if (rx_data >= 8'h30 && rx_data <= 8'h39)       // 0-9
            nib = 4'(rx_data - 8'h30);
        else if (rx_data >= 8'h41 && rx_data <= 8'h46)  // A-F
            nib = 4'(rx_data - 8'h37);
        else if (rx_data >= 8'h61 && rx_data <= 8'h66)  // a-f
            nib = 4'(rx_data - 8'h57);
        else
            is_hex = 1'b0;
    end

    //////////////////////////////////////////////////////////////////////
    // token FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state    <= st_idle;
            dig_cnt  <= '0;
            scan_res <= '0;
        end
        else
        begin
            case (state)
                st_idle:
                begin
                    // rx_vld ignored here
                    if (scan_req)
                    begin
                        scan_res <= '0;
                        dig_cnt  <= '0;
                        state    <= (scan_kind == uart_mon_pkg::scan_addr) ? st_addr : st_byte;
                    end
                end
                st_byte:
                begin
                    if (rx_vld)
                    begin
                        if (rx_data == uart_mon_pkg::chr_cr)
                            state <= st_enter;
                        else if (rx_data != uart_mon_pkg::chr_sp)
                        begin
                            scan_res.value <= {8'h00, rx_data};
                            state          <= st_done;
                        end
                    end
                end
                st_addr:
                begin
                    if (rx_vld)
                    begin
                        if (rx_data == uart_mon_pkg::chr_cr)
                            state <= st_enter;
                        else if (is_hex)
                        begin
                            scan_res.value <= {scan_res.value[11:0], nib};
                            if (dig_cnt == uart_mon_pkg::addr_digits - 1)
                                state <= st_done;
                            else
                                dig_cnt <= dig_cnt + 1'b1;
                        end
                        // other filler is skipped
                    end
                end
                st_enter:
                begin
                    if (rx_vld && rx_data == uart_mon_pkg::chr_lf)
                    begin
                        scan_res.abort <= 1'b1;
                        state          <= st_done;
                    end
                end
                st_done: state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    // one cycle after the completing rx_vld
    assign scan_done = (state == st_done);

endmodule

/* uart_mon.f */
common/uart_mon_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
scan/scan.sv
monitor/mon_ctrl.sv
hdl/uart_mon_top.sv
verif/tb_clk_gen.sv
verif/tb_uart_mon.sv

/* verif/tb_clk_gen.sv */
module tb_clk_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    // 40 ns period
    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial
    begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;  // released on a rising edge
    end

endmodule

/* verif/tb_uart_mon.sv */
module tb_uart_mon;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int bit_cycles = uart_mon_pkg::clks_per_bit;
    localparam int n_pairs    = 6;  // random write/read pairs

    logic        clk;
    logic        rst;
    logic        rxd;
    logic        txd;
    logic        reply_expected;  // a reply may be on txd
    logic [7:0]  reply_q [$];
    string       cmd_q [$];
    int          exp_q [$];       // -1 for no reply
    logic [7:0]  ref_mem [256];
    logic [15:0] lfsr;
    longint      budget_ns;

    tb_clk_gen i_tb_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    uart_mon_top i_uart_mon_top (
        .clk (clk),
        .rst (rst),
        .rxd (rxd),
        .txd (txd)
    );

    //////////////////////////////////////////////////////////////////////
    // failure reporting and helpers
    //////////////////////////////////////////////////////////////////////

    task automatic halt_run(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string sig, input logic [7:0] exp, input logic [7:0] got);
        halt_run($sformatf("MISMATCH time=%0t signal=%s expected=%h actual=%h",
                           $time, sig, exp, got));
    endtask

    // fibonacci lfsr on taps 16 14 13 11 stepped once per bit
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[14:0], fb};
        end
        return v;
    endfunction

    function automatic string hex_text(input logic [15:0] a, input logic upper);
        string      s;
        logic [3:0] n;
        s = "";
        for (int i = 3; i >= 0; i--)
        begin
            n = a[i*4 +: 4];
            if (n < 4'd10)
                s = {s, $sformatf("%c", 8'(8'h30 + n))};
            else
                s = {s, $sformatf("%c", 8'((upper ? 8'h37 : 8'h57) + n))};
        end
        return s;
    endfunction

    task automatic add_cmd(input string cmd, input int exp);
        cmd_q.push_back(cmd);
        exp_q.push_back(exp);
    endtask

    // command list with expected replies from the reference store
    task automatic build_script();
        logic [15:0] addr;
        logic [7:0]  c;
        logic        upper;
        for (int k = 0; k < n_pairs; k++)
        begin
            addr  = rand_bits(16);
            c     = 8'(8'h21 + (rand_bits(7) % 94));  // printable and never a space
            upper = 1'(rand_bits(1));
            ref_mem[addr[7:0]] = c;
            add_cmd($sformatf("w %s %c", hex_text(addr, upper), c), uart_mon_pkg::chr_k);
            add_cmd($sformatf("r %s", hex_text(addr, !upper)), ref_mem[addr[7:0]]);
        end
        // spaces and filler before tokens with mixed case digits
        ref_mem[8'hab] = "Q";
        add_cmd("  w  ..:01aB   Q", uart_mon_pkg::chr_k);
        add_cmd(" r zz01AB", ref_mem[8'hab]);
        add_cmd("r 01ab", ref_mem[8'hab]);
        // upper address bits ignored
        ref_mem[8'hc4] = "m";
        add_cmd("w 12C4 m", uart_mon_pkg::chr_k);
        add_cmd("r 34c4", ref_mem[8'hc4]);
        add_cmd("r FFc4", ref_mem[8'hc4]);
        add_cmd("x", uart_mon_pkg::chr_q);
        add_cmd("   Z", uart_mon_pkg::chr_q);
        // aborted requests where \015\012 is CR LF
        ref_mem[8'ha0] = "a";
        add_cmd("w 00A0 a", uart_mon_pkg::chr_k);
        add_cmd("w 00\015\012", -1);
        add_cmd("w 00A0 \015q\012", -1);  // junk between CR and LF
        add_cmd(" \015\012", -1);
        add_cmd("r 00a0", ref_mem[8'ha0]);
    endtask

    //////////////////////////////////////////////////////////////////////
    // serial host model
    //////////////////////////////////////////////////////////////////////

    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};  // stop, data lsb first, start
        for (int i = 0; i < 10; i++)
        begin
            @(posedge clk);
            rxd <= frame[i];
            repeat (bit_cycles - 1) @(posedge clk);
        end
    endtask

    task automatic check_reply(input logic [7:0] exp);
        logic [7:0] want [3];
        logic [7:0] got;
        want[0] = exp;
        want[1] = uart_mon_pkg::chr_cr;
        want[2] = uart_mon_pkg::chr_lf;
        while (reply_q.size() < 3)
            @(posedge clk);
        for (int i = 0; i < 3; i++)
        begin
            got = reply_q.pop_front();
            assert (got == want[i])
                else report_mismatch("txd", want[i], got);
        end
        reply_expected <= 1'b0;
    endtask

    task automatic run_cmd(input string cmd, input int exp);
        @(posedge clk);
        reply_expected <= (exp >= 0);
        for (int i = 0; i < cmd.len(); i++)
            send_byte(cmd[i]);
        if (exp >= 0)
            check_reply(8'(exp));
        repeat (bit_cycles) @(posedge clk);  // let the DUT listen again
    endtask

    // txd decode sampled at bit middles
    initial
    begin
        logic [7:0] b;
        forever
        begin
            @(posedge clk);
            if (!rst && txd === 1'b0)
            begin
                repeat (bit_cycles / 2) @(posedge clk);
                assert (txd === 1'b0)
                    else halt_run("start bit on txd did not last to its middle");
                for (int i = 0; i < 8; i++)
                begin
                    repeat (bit_cycles) @(posedge clk);
                    b[i] = txd;
                end
                repeat (bit_cycles) @(posedge clk);
                assert (txd === 1'b1)
                    else halt_run("stop bit on txd was missing");
                reply_q.push_back(b);
            end
        end
    end

    // txd idles high after reset and aborts unless a reply is due
    assert property (@(posedge clk) disable iff (rst) !txd |-> reply_expected)
        else halt_run("txd went low while no reply was pending");

    //////////////////////////////////////////////////////////////////////
    // main sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        longint chars;
        rxd            = 1'b1;
        reply_expected = 1'b0;
        budget_ns      = 0;
        lfsr           = 16'd7;
        chars          = 0;
        build_script();
        for (int k = 0; k < cmd_q.size(); k++)
            chars += cmd_q[k].len() + ((exp_q[k] >= 0) ? 3 : 0);
        budget_ns = chars * 10 * bit_cycles * 40 * 4;
        while (rst)
            @(posedge clk);
        repeat (2) @(posedge clk);
        assert (txd === 1'b1)
            else report_mismatch("txd", 8'h01, {7'b0, txd});
        for (int k = 0; k < cmd_q.size(); k++)
            run_cmd(cmd_q[k], exp_q[k]);
        repeat (20 * bit_cycles) @(posedge clk);
        assert (reply_q.size() == 0)
            else halt_run("extra bytes appeared on txd after the last reply");
        $display("test passed");
        $finish;
    end

    initial
    begin
        wait (budget_ns > 0);
        #(budget_ns);
        halt_run("watchdog expired before all commands completed");
    end

endmodule
